/* flist.f */
+incdir+source
source/cpu_pkg.sv
source/cpu_ifc.sv
source/apb_loader.sv
source/reg_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/single_cpu.sv
tb/clock_gen.sv
tb/cpu_tb.sv

/* source/apb_loader.sv */
`include "cpu_macros.svh"

module apb_loader (
    input  logic             CLK,
    input  logic             rstN,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [`XLEN-1:0] paddr,
    input  logic [`XLEN-1:0] pwdata,
    output logic [`XLEN-1:0] prdata,
    output logic             pready,
    output logic             pslverr,
    input  logic [`XLEN-1:0] fetchAddr,
    output logic [`XLEN-1:0] instr,
    input  logic             haltReq,
    output logic             running,
    output logic             halted
);
    localparam int IMEM_AW = $clog2(`IMEM_WORDS);
    localparam logic [`XLEN-1:0] IMEM_BYTES = `IMEM_WORDS * 4;

    logic [`XLEN-1:0] imem [`IMEM_WORDS];

    logic access;
    logic isImem;
    logic isCtrl;
    logic accessErr;

    assign access = psel && penable;           // Access phase
    assign isImem = paddr < IMEM_BYTES;
    assign isCtrl = paddr == `CTRL_ADDR;

    // Program must not change under a running core
    assign accessErr = (isImem && pwrite && running) || (!isImem && !isCtrl);

    assign pready  = access;                   // Zero wait states
    assign pslverr = access && accessErr;

    always_comb begin
        prdata = '0;
        if (isImem) begin
            prdata = imem[paddr[IMEM_AW+1:2]];
        end else if (isCtrl) begin
            prdata[0] = running;
            prdata[1] = halted;
        end
    end

    always_ff @(posedge CLK) begin
        if (access && pwrite && isImem && !accessErr) begin
            imem[paddr[IMEM_AW+1:2]] <= pwdata;
        end
    end

    // Run/halt state; ECALL wins over a same-cycle APB write
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (haltReq) begin
            running <= 1'b0;
            halted  <= 1'b1;
        end else if (access && pwrite && isCtrl) begin
            running <= pwdata[0];
            if (pwdata[0]) begin
                halted <= 1'b0;                // Fresh start
            end
        end
    end

    // Fetch past the end of memory yields a no-op word
    assign instr = (fetchAddr < IMEM_BYTES) ? imem[fetchAddr[IMEM_AW+1:2]] : '0;

endmodule

/* source/cpu_ifc.sv */
`include "cpu_macros.svh"

// Decode to execute
interface decodeBus;
    import cpu_pkg::*;

    logic [`XLEN-1:0]             pc;
    logic [`XLEN-1:0]             rs1Data;
    logic [`XLEN-1:0]             rs2Data;
    logic [`XLEN-1:0]             imm;
    logic [$clog2(`REG_COUNT)-1:0] rd;
    ctrlT                         ctrl;

    modport dec (output pc, rs1Data, rs2Data, imm, rd, ctrl);
    modport exe (input pc, rs1Data, rs2Data, imm, rd, ctrl);
endinterface

// Execute to result
interface execBus;
    import cpu_pkg::*;

    logic [`XLEN-1:0]             aluResult;
    logic [`XLEN-1:0]             storeData;
    logic [$clog2(`REG_COUNT)-1:0] rd;
    ctrlT                         ctrl;

    modport exe (output aluResult, storeData, rd, ctrl);
    modport res (input aluResult, storeData, rd, ctrl);
endinterface

/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath width
`define XLEN 32

// Architectural registers x0..x31
`define REG_COUNT 32

// Memory depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// APB map: instruction memory from 0, control register above it
`define CTRL_ADDR 32'h0000_0100

`endif

/* source/cpu_pkg.sv */
package cpu_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    // Control word, one per decoded instruction
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;   // 1 selects immediate as ALU operand B
        logic  memRead;
        logic  memWrite;
        logic  memToReg; // 1 writes back the loaded word
        logic  branch;
        logic  halt;     // ECALL
        aluOpT aluOp;
    } ctrlT;

endpackage

/* source/decode_unit.sv */
`include "cpu_macros.svh"

module decode_unit (
    input  logic [`XLEN-1:0]              instr,
    input  logic [`XLEN-1:0]              pc,
    output logic [$clog2(`REG_COUNT)-1:0] rs1,
    output logic [$clog2(`REG_COUNT)-1:0] rs2,
    input  logic [`XLEN-1:0]              rs1Data,
    input  logic [`XLEN-1:0]              rs2Data,
    decodeBus.dec                         dBus
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    ctrlT       ctrl;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        ctrl       = '0;                       // No side effects by default
        ctrl.aluOp = ALU_ADD;
        dBus.imm   = '0;
        case (opcode)
            OP: begin
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    ctrl.regWrite = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.aluOp = funct7[5] ? ALU_SUB : ALU_ADD;
                        3'b010:  ctrl.aluOp = ALU_SLT;
                        3'b110:  ctrl.aluOp = ALU_OR;
                        3'b111:  ctrl.aluOp = ALU_AND;
                        default: ctrl.regWrite = 1'b0;  // Unsupported R-type
                    endcase
                end
            end
            OP_IMM: begin
                dBus.imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b000) begin        // ADDI only
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
            end
            LOAD: begin
                dBus.imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b010) begin        // LW
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                end
            end
            STORE: begin
                dBus.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (funct3 == 3'b010) begin        // SW
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
            end
            BRANCH: begin
                // Offset already in bytes
                dBus.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
                if (funct3 == 3'b000) begin        // BEQ
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = ALU_SUB;
                end
            end
            SYSTEM: begin
                ctrl.halt = instr[31:7] == '0;     // ECALL
            end
            default: ;
        endcase
    end

    assign dBus.pc      = pc;
    assign dBus.rs1Data = rs1Data;
    assign dBus.rs2Data = rs2Data;
    assign dBus.rd      = instr[11:7];
    assign dBus.ctrl    = ctrl;

endmodule

/* source/execute_unit.sv */
`include "cpu_macros.svh"

module execute_unit (
    input  logic             CLK,
    input  logic             rstN,
    input  logic             running,
    decodeBus.exe            dBus,
    execBus.exe              eBus,
    output logic [`XLEN-1:0] pc
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] pcReg;
    logic             runningQ;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] branchTarget;
    logic             taken;
    logic [`XLEN-1:0] nextPc;

    assign opB = dBus.ctrl.aluSrc ? dBus.imm : dBus.rs2Data;

    always_comb begin
        case (dBus.ctrl.aluOp)
            ALU_ADD: aluOut = dBus.rs1Data + opB;
            ALU_SUB: aluOut = dBus.rs1Data - opB;
            ALU_AND: aluOut = dBus.rs1Data & opB;
            ALU_OR:  aluOut = dBus.rs1Data | opB;
            ALU_SLT: aluOut = {{(`XLEN-1){1'b0}}, $signed(dBus.rs1Data) < $signed(opB)};
            default: aluOut = '0;
        endcase
    end

    // BEQ
    assign taken        = dBus.ctrl.branch && (dBus.rs1Data == dBus.rs2Data);
    assign pcPlus4      = dBus.pc + 32'd4;
    assign branchTarget = dBus.pc + dBus.imm;

    always_comb begin
        if (dBus.ctrl.halt) begin
            nextPc = dBus.pc;                  // ECALL parks the pc
        end else if (taken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pcReg    <= '0;
            runningQ <= 1'b0;
        end else begin
            runningQ <= running;
            if (running) begin
                pcReg <= nextPc;
            end
        end
    end

    // First running cycle always fetches from address 0
    assign pc = (running && !runningQ) ? '0 : pcReg;

    assign eBus.aluResult = aluOut;
    assign eBus.storeData = dBus.rs2Data;
    assign eBus.rd        = dBus.rd;
    assign eBus.ctrl      = dBus.ctrl;

endmodule

/* source/reg_file.sv */
`include "cpu_macros.svh"

module reg_file (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1,
    input  logic [$clog2(`REG_COUNT)-1:0] rs2,
    output logic [`XLEN-1:0]              rs1Data,
    output logic [`XLEN-1:0]              rs2Data,
    input  logic                          we,
    input  logic [$clog2(`REG_COUNT)-1:0] rd,
    input  logic [`XLEN-1:0]              wd
);
    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // Asynchronous read ports
    always_comb begin
        rs1Data = '0;
        if (rs1 != '0) begin
            rs1Data = regs[rs1];
        end
    end

    always_comb begin
        rs2Data = '0;
        if (rs2 != '0) begin
            rs2Data = regs[rs2];
        end
    end

endmodule

/* source/result_unit.sv */
`include "cpu_macros.svh"

module result_unit (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic                          running,
    execBus.res                           eBus,
    output logic                          we,
    output logic [$clog2(`REG_COUNT)-1:0] rd,
    output logic [`XLEN-1:0]              wd,
    output logic                          haltReq
);
    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0] wordIdx;
    logic [`XLEN-1:0]   loadData;

    assign wordIdx = eBus.aluResult[DMEM_AW+1:2];   // Drop byte offset

    // Data memory starts out zeroed
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (running && eBus.ctrl.memWrite) begin
            dmem[wordIdx] <= eBus.storeData;          // SW
        end
    end

    assign loadData = eBus.ctrl.memRead ? dmem[wordIdx] : '0;

    // Writeback port
    assign wd      = eBus.ctrl.memToReg ? loadData : eBus.aluResult;
    assign rd      = eBus.rd;
    assign we      = running && eBus.ctrl.regWrite && (eBus.rd != '0);

    assign haltReq = running && eBus.ctrl.halt;

endmodule

/* source/single_cpu.sv */
`include "cpu_macros.svh"

module single_cpu (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`XLEN-1:0]              paddr,
    input  logic [`XLEN-1:0]              pwdata,
    output logic [`XLEN-1:0]              prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic [`XLEN-1:0]              pc,
    output logic                          wbValid,
    output logic [$clog2(`REG_COUNT)-1:0] wbReg,
    output logic [`XLEN-1:0]              wbData,
    output logic                          halted
);
    logic [`XLEN-1:0]              instr;
    logic [$clog2(`REG_COUNT)-1:0] rs1;
    logic [$clog2(`REG_COUNT)-1:0] rs2;
    logic [`XLEN-1:0]              rs1Data;
    logic [`XLEN-1:0]              rs2Data;
    logic                          haltReq;
    logic                          running;

    decodeBus dBus ();
    execBus   eBus ();

    apb_loader uLoader (
        .CLK(CLK), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .fetchAddr(pc), .instr(instr),
        .haltReq(haltReq), .running(running), .halted(halted)
    );

    reg_file uRegs (
        .CLK(CLK), .rstN(rstN),
        .rs1(rs1), .rs2(rs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .we(wbValid), .rd(wbReg), .wd(wbData)   // Write port doubles as the trace
    );

    decode_unit uDecode (
        .instr(instr), .pc(pc),
        .rs1(rs1), .rs2(rs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .dBus(dBus.dec)
    );

    execute_unit uExecute (
        .CLK(CLK), .rstN(rstN), .running(running),
        .dBus(dBus.exe), .eBus(eBus.exe), .pc(pc)
    );

    result_unit uResult (
        .CLK(CLK), .rstN(rstN), .running(running),
        .eBus(eBus.res),
        .we(wbValid), .rd(wbReg), .wd(wbData),
        .haltReq(haltReq)
    );

endmodule

/* tb/clock_gen.sv */
module clock_gen (
    output logic CLK,
    output logic rstN
);
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;                // 40-unit period
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge CLK);
        rstN <= 1'b1;
    end
endmodule

/* tb/cpu_tb.sv */
`include "cpu_macros.svh"

module cpu_tb;
    // Room for 3 programs of up to 40 words at 6 APB cycles and 40 steps each plus margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

    logic CLK, rstN;
    logic psel, penable, pwrite, pready, pslverr, wbValid, halted;
    logic [`XLEN-1:0] paddr, pwdata, prdata, pc, wbData;
    logic [4:0] wbReg;
    logic expErr, checkRead;                   // Expected APB response
    logic [`XLEN-1:0] expRdata;
    logic [31:0] prog [64];                    // Expected instruction memory
    logic [31:0] mRegs [32];
    logic [31:0] mMem [64];
    logic [31:0] mPc, mInstr, mA, mB, mAddr, mRes, mNextPc;
    logic mRun, mHalted, mWrite, expValid;
    int progLen;
    int errors = 0;
    int cycles = 0;

    clock_gen uClock (.CLK(CLK), .rstN(rstN));

    single_cpu DUT (.*);

    // Reference model retires one instruction per running cycle
    always_comb begin
        mInstr  = prog[mPc[7:2]];
        mA      = mRegs[mInstr[19:15]];
        mB      = mRegs[mInstr[24:20]];
        mAddr   = mA + ((mInstr[6:0] == 7'h23) ? {{20{mInstr[31]}}, mInstr[31:25], mInstr[11:7]}
                                               : {{20{mInstr[31]}}, mInstr[31:20]});
        mRes    = mA + {{20{mInstr[31]}}, mInstr[31:20]};   // ADDI
        mWrite  = mInstr[6:0] inside {7'h33, 7'h13, 7'h03};
        mNextPc = mPc + 32'd4;
        case (mInstr[6:0])
            7'h33: begin
                case ({mInstr[30], mInstr[14:12]})
                    4'b1000: mRes = mA - mB;
                    4'b0111: mRes = mA & mB;
                    4'b0110: mRes = mA | mB;
                    4'b0010: mRes = {31'd0, $signed(mA) < $signed(mB)};
                    default: mRes = mA + mB;
                endcase
            end
            7'h03: mRes = mMem[mAddr[7:2]];
            7'h63: begin
                if (mA == mB) begin
                    mNextPc = mPc + {{19{mInstr[31]}}, mInstr[31], mInstr[7], mInstr[30:25],
                                     mInstr[11:8], 1'b0};
                end
            end
            7'h73: mNextPc = mPc;              // Halt keeps pc
            default: ;
        endcase
        expValid = mRun && mWrite && (mInstr[11:7] != 5'd0);
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            mRun    <= 1'b0;
            mHalted <= 1'b0;
            mPc     <= '0;
            for (int i = 0; i < 64; i++) begin
                mMem[i] <= '0;
            end
            for (int i = 0; i < 32; i++) begin
                mRegs[i] <= '0;
            end
        end else if (mRun) begin
            if (mInstr[6:0] == 7'h73) begin
                mRun    <= 1'b0;
                mHalted <= 1'b1;
            end
            if (expValid) begin
                mRegs[mInstr[11:7]] <= mRes;
            end
            if (mInstr[6:0] == 7'h23) begin
                mMem[mAddr[7:2]] <= mB;
            end
            mPc <= mNextPc;
        end else if (psel && penable && pwrite && paddr == `CTRL_ADDR && pwdata[0]) begin
            mRun    <= 1'b1;                   // Fetch restarts at 0
            mHalted <= 1'b0;
            mPc     <= '0;
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errors++;
        $display("FAILED %s: got %h expected %h at cycle %0d", name, got, exp, cycles);
    endtask

    assert property (@(posedge CLK) disable iff (!rstN) pc == mPc)
        else reportMismatch("pc", $sampled(pc), $sampled(mPc));
    assert property (@(posedge CLK) disable iff (!rstN) wbValid == expValid)
        else reportMismatch("wbValid", {31'd0, $sampled(wbValid)}, {31'd0, $sampled(expValid)});
    assert property (@(posedge CLK) disable iff (!rstN) expValid |-> wbReg == mInstr[11:7])
        else reportMismatch("wbReg", {27'd0, $sampled(wbReg)}, {27'd0, $sampled(mInstr[11:7])});
    assert property (@(posedge CLK) disable iff (!rstN) expValid |-> wbData == mRes)
        else reportMismatch("wbData", $sampled(wbData), $sampled(mRes));
    assert property (@(posedge CLK) disable iff (!rstN) halted == mHalted)
        else reportMismatch("halted", {31'd0, $sampled(halted)}, {31'd0, $sampled(mHalted)});
    assert property (@(posedge CLK) disable iff (!rstN) pready == (psel && penable))
        else reportMismatch("pready", {31'd0, $sampled(pready)},
                            {31'd0, $sampled(psel && penable)});
    assert property (@(posedge CLK) disable iff (!rstN) psel && penable |-> pslverr == expErr)
        else reportMismatch("pslverr", {31'd0, $sampled(pslverr)}, {31'd0, $sampled(expErr)});
    assert property (@(posedge CLK) disable iff (!rstN)
                     psel && penable && checkRead |-> prdata == expRdata)
        else reportMismatch("prdata", $sampled(prdata), $sampled(expRdata));

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish in %0d cycles, %0d errors", cycles, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // One APB transfer from setup through access until PREADY
    task automatic apbAccess(input logic write, input logic [31:0] addr,
                             input logic [31:0] data, input logic err);
        @(posedge CLK);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= write;
        paddr     <= addr;
        pwdata    <= write ? data : '0;
        expErr    <= err;
        checkRead <= !write;
        expRdata  <= data;
        @(posedge CLK);
        penable <= 1'b1;
        @(posedge CLK);
        while (!pready) begin
            @(posedge CLK);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic [31:0] encodeR(input int sel, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        case (sel)
            2: f3 = 3'b111;                    // AND
            3: f3 = 3'b110;                    // OR
            4: f3 = 3'b010;                    // SLT
            default: f3 = 3'b000;
        endcase
        return {(sel == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encodeI(input logic [6:0] op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, (op == 7'h03) ? 3'b010 : 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encodeB(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
    endfunction

    task automatic addInstr(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // Load with readback, run to ECALL, then probe the halted core
    task automatic runProgram();
        for (int i = 0; i < progLen; i++) begin
            apbAccess(1'b1, i * 4, prog[i], 1'b0);
            apbAccess(1'b0, i * 4, prog[i], 1'b0);
        end
        apbAccess(1'b1, `CTRL_ADDR, 32'h1, 1'b0);
        apbAccess(1'b1, 32'h0, ~prog[0], 1'b1);            // Core still running
        apbAccess(1'b1, 32'h200, 32'hdead_beef, 1'b1);     // Unmapped
        while (!halted) begin
            @(posedge CLK);
        end
        repeat (3) @(posedge CLK);
        apbAccess(1'b0, `CTRL_ADDR, 32'h2, 1'b0);
        apbAccess(1'b0, 32'h0, prog[0], 1'b0);
        progLen = 0;
    endtask

    initial begin
        logic [11:0] base, off1, off2;
        void'($urandom(32'hf8aa));
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        expErr    = 1'b0;
        checkRead = 1'b0;
        expRdata  = '0;
        progLen   = 0;
        for (int i = 0; i < 64; i++) begin
            prog[i] = '0;
        end
        wait (rstN === 1'b1);

        // ALU program on random values
        for (int r = 1; r <= 5; r++) begin
            addInstr(encodeI(7'h13, 5'(r), 5'd0, 12'($urandom)));
        end
        addInstr(encodeR(0, 5'd0, 5'd1, 5'd2));           // x0 target
        for (int k = 0; k < 10; k++) begin
            addInstr(encodeR(int'($urandom % 5), 5'(1 + $urandom % 7),
                             5'(1 + $urandom % 5), 5'(1 + $urandom % 5)));
        end
        addInstr(ECALL_WORD);
        runProgram();

        // Memory program
        base = 12'(($urandom % 32) * 4);
        off1 = 12'(($urandom % 32) * 4);
        off2 = 12'(($urandom % 32) * 4);
        addInstr(encodeI(7'h13, 5'd6, 5'd0, base));
        addInstr(encodeI(7'h03, 5'd9, 5'd0, 12'd252));    // Never stored to
        addInstr(encodeS(5'd3, 5'd6, off1));
        addInstr(encodeS(5'd4, 5'd6, off2));
        addInstr(encodeI(7'h03, 5'd8, 5'd6, off1));
        addInstr(encodeI(7'h03, 5'd10, 5'd6, off2));
        addInstr(encodeR(0, 5'd11, 5'd8, 5'd10));
        addInstr(ECALL_WORD);
        runProgram();

        // Branch program
        addInstr(encodeI(7'h13, 5'd1, 5'd0, 12'($urandom) | 12'd1));
        addInstr(encodeI(7'h13, 5'd2, 5'd1, 12'd0));
        addInstr(encodeB(5'd1, 5'd2, 13'd8));             // Taken
        addInstr(encodeI(7'h13, 5'd12, 5'd0, 12'd1));
        addInstr(encodeB(5'd1, 5'd0, 13'd8));             // Not taken
        addInstr(encodeI(7'h13, 5'd13, 5'd0, 12'($urandom)));
        addInstr(encodeB(5'($urandom % 4), 5'($urandom % 4), 13'd8));
        addInstr(encodeI(7'h13, 5'd14, 5'd13, 12'd5));
        addInstr(encodeB(5'd0, 5'd0, 13'd12));            // Skips two
        addInstr(encodeI(7'h13, 5'd15, 5'd0, 12'd7));
        addInstr(encodeI(7'h13, 5'd16, 5'd0, 12'd9));
        addInstr(encodeI(7'h13, 5'd17, 5'd14, 12'($urandom)));
        addInstr(ECALL_WORD);
        runProgram();

        $display("Run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule
